// ==== sim.f ====
source/xc_pkg.sv
source/xc_cfg_if.sv
source/cmd_parser.sv
source/pwm_bank.sv
source/sample_tick_gen.sv
source/xc_ctrl_top.sv
sim/tb_xc_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the correlator control testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
	--top-module tb_xc_ctrl \
	-f sim.f \
	-Mdir "$OBJ" \
	-o tb_xc_ctrl
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

"./$OBJ/tb_xc_ctrl" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" "$LOG"; then
	exit 0
fi

echo "pass message not found in $LOG"
exit 1

// ==== sim/tb_xc_ctrl.sv ====
// random command stream against a settings model, then pwm duty and tick counts.
// inputs change 1 ns after the rising edge; outputs are sampled at that same point.
`default_nettype none

module tb_xc_ctrl;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PERIOD = 10;
	localparam int RESET_CYCLES = 4;
	localparam int NUM_CMDS = 2000; // random bytes with a strobe.
	localparam int PWM_CYCLES = 256; // one full phase period.
	localparam int ROUNDS = 4; // internal divider rounds.
	localparam int MAX_WINDOW = 64 * 16; // largest divider window.
	localparam int EXT_CYCLES = 400;
	localparam int NUM_TESTS = 5;
	// bound over all tests plus slack for setup commands.
	localparam int PLAN_CYCLES = RESET_CYCLES + NUM_CMDS + 2 * NUM_CMDS
		+ 30 + PWM_CYCLES + ROUNDS * (2 * (MAX_WINDOW + 4)) + EXT_CYCLES + 10;
	localparam int TIMEOUT_NS = PLAN_CYCLES * PERIOD + 2000;

	logic clk;
	logic rst_n;
	xc_pkg::cmd_t cmd;
	logic cmd_valid;
	logic ext_tick;
	logic [xc_pkg::NUM_LINES-1:0] pwm;
	logic sample_tick;
	logic integrating;
	logic external_clock;
	xc_pkg::nibble_t clock_divider;
	xc_pkg::nibble_t baud_rate;
	xc_pkg::line_t current_line;
	xc_pkg::nibble_t [xc_pkg::NUM_LINES-1:0] test;
	xc_pkg::nibble_t [xc_pkg::NUM_LINES-1:0] leds;
	xc_pkg::delay_idx_t [xc_pkg::NUM_LINES-1:0] cross_idx;
	xc_pkg::delay_idx_t [xc_pkg::NUM_LINES-1:0] auto_idx;

	// settings model.
	logic [3:0] m_test [xc_pkg::NUM_LINES];
	logic [3:0] m_leds [xc_pkg::NUM_LINES];
	logic [11:0] m_cross [xc_pkg::NUM_LINES];
	logic [11:0] m_auto [xc_pkg::NUM_LINES];
	logic [7:0] m_volt [xc_pkg::NUM_LINES];
	logic [3:0] m_baud;
	logic [3:0] m_div;
	logic [7:0] m_line;
	logic m_integ;
	logic m_ext;

	// codes the stream favours. 4..7 are the delay taps.
	logic [3:0] valid_ops [12] = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5,
		4'd6, 4'd7, 4'd8, 4'd9, 4'd12, 4'd13};

	int errors;
	int failed_tests;

	xc_ctrl_top dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.cmd            (cmd),
		.cmd_valid      (cmd_valid),
		.ext_tick       (ext_tick),
		.pwm            (pwm),
		.sample_tick    (sample_tick),
		.integrating    (integrating),
		.external_clock (external_clock),
		.clock_divider  (clock_divider),
		.baud_rate      (baud_rate),
		.current_line   (current_line),
		.test           (test),
		.leds           (leds),
		.cross_idx      (cross_idx),
		.auto_idx       (auto_idx)
	);

	always #(PERIOD / 2) clk = ~clk; // 10 ns period.

	// watchdog.
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: tests still running after %0d ns", TIMEOUT_NS);
		$display("sim failed");
		$finish;
	end

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp) else begin
			$display("ERROR at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	// command rules applied to the model.
	function automatic void apply_model(input xc_pkg::cmd_t c);
		logic [1:0] sel;
		int tap;
		int pos;
		sel = m_line[1:0]; // only low two selector bits count.
		tap = 3 * int'(c[1:0]);
		pos = 2 * int'(c[7:6]);
		if (c[3:2] == 2'b01) begin
			if (c[7])
				m_auto[sel][tap +: 3] = c[6:4];
			else
				m_cross[sel][tap +: 3] = c[6:4];
		end else begin
			case (c[3:0])
				4'd0: begin
					m_cross[sel] = '0;
					m_auto[sel] = '0;
				end
				4'd1: m_line[pos +: 2] = c[5:4];
				4'd2: m_leds[sel] = c[7:4];
				4'd3: m_baud = c[7:4];
				4'd8: m_div = c[7:4];
				4'd9: m_volt[sel][pos +: 2] = c[5:4];
				4'd12: m_test[sel] = c[7:4];
				4'd13: begin
					m_integ = c[4];
					m_ext = c[5];
				end
				default: ; // ignored codes.
			endcase
		end
	endfunction

	task automatic check_settings();
		for (int i = 0; i < xc_pkg::NUM_LINES; i++) begin
			check_value($sformatf("test[%0d]", i), 32'(test[i]), 32'(m_test[i]));
			check_value($sformatf("leds[%0d]", i), 32'(leds[i]), 32'(m_leds[i]));
			check_value($sformatf("cross_idx[%0d]", i), 32'(cross_idx[i]), 32'(m_cross[i]));
			check_value($sformatf("auto_idx[%0d]", i), 32'(auto_idx[i]), 32'(m_auto[i]));
		end
		check_value("baud_rate", 32'(baud_rate), 32'(m_baud));
		check_value("clock_divider", 32'(clock_divider), 32'(m_div));
		check_value("current_line", 32'(current_line), 32'(m_line));
		check_value("integrating", 32'(integrating), 32'(m_integ));
		check_value("external_clock", 32'(external_clock), 32'(m_ext));
	endtask

	// one clock. checks what the last edge took, then drives the next byte.
	task automatic step(input xc_pkg::cmd_t c, input logic v);
		@(posedge clk);
		#1;
		check_settings();
		cmd = c;
		cmd_valid = v;
		if (v)
			apply_model(c);
	endtask

	// mostly valid opcodes, random argument.
	function automatic xc_pkg::cmd_t random_cmd();
		logic [31:0] r;
		logic [3:0] op;
		r = $urandom;
		if (r[10:8] != 3'd0)
			op = valid_ops[int'(r[19:12]) % 12];
		else
			op = r[3:0]; // any code, unused ones included.
		return {r[7:4], op};
	endfunction

	task automatic select_line(input logic [1:0] l);
		step({2'b00, l, 4'd1}, 1'b1); // pair 0 of the selector.
	endtask

	task automatic set_voltage(input logic [7:0] v);
		for (int p = 0; p < 4; p++)
			step({2'(p), v[2*p +: 2], 4'd9}, 1'b1);
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: FAILED with %0d errors", name, errors - errs_before);
			failed_tests++;
		end
	endtask

	initial begin
		int mark;
		int ticks;
		int ext_count;
		int tick_count;
		int window;
		int high [xc_pkg::NUM_LINES];
		logic [31:0] r;
		logic [3:0] d;
		logic prev_ext;

		void'($urandom(73)); // fixed seed.
		clk = 1'b0;
		rst_n = 1'b0;
		cmd = '0;
		cmd_valid = 1'b0;
		ext_tick = 1'b0;
		errors = 0;
		failed_tests = 0;
		for (int i = 0; i < xc_pkg::NUM_LINES; i++) begin
			m_test[i] = '0;
			m_leds[i] = '0;
			m_cross[i] = '0;
			m_auto[i] = '0;
			m_volt[i] = '0;
		end
		m_baud = '0;
		m_div = '0;
		m_line = '0;
		m_integ = 1'b0;
		m_ext = 1'b0;

		// 1. reset.
		mark = errors;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_settings();
		check_value("pwm", 32'(pwm), 32'd0);
		check_value("sample_tick", 32'(sample_tick), 32'd0);
		report_test("reset", mark);

		// 2. random command stream with random strobe gaps.
		mark = errors;
		for (int n = 0; n < NUM_CMDS; n++) begin
			r = $urandom;
			while (r[1:0] == 2'd0) begin
				step(random_cmd(), 1'b0); // byte without strobe is ignored.
				r = $urandom;
			end
			step(random_cmd(), 1'b1);
		end
		step(8'h00, 1'b0); // check the last byte.
		report_test("command stream", mark);

		// 3. pwm duty per line.
		mark = errors;
		for (int i = 0; i < xc_pkg::NUM_LINES; i++) begin
			r = $urandom;
			select_line(2'(i));
			set_voltage(r[7:0]);
		end
		step(8'h00, 1'b0); // voltage lands.
		step(8'h00, 1'b0); // first compare with it.
		for (int i = 0; i < xc_pkg::NUM_LINES; i++)
			high[i] = 0;
		repeat (PWM_CYCLES) begin
			step(8'h00, 1'b0);
			for (int i = 0; i < xc_pkg::NUM_LINES; i++)
				if (pwm[i])
					high[i]++;
		end
		for (int i = 0; i < xc_pkg::NUM_LINES; i++)
			check_value($sformatf("pwm[%0d] high count", i), 32'(high[i]), 32'(m_volt[i]));
		report_test("pwm duty", mark);

		// 4. internal divider ticks.
		mark = errors;
		for (int k = 0; k < ROUNDS; k++) begin
			r = $urandom;
			d = r[3:0];
			window = 64 * (int'(d) + 1);
			step(8'h0D, 1'b1); // capture off, internal source.
			step({d, 4'd8}, 1'b1);
			step(8'h1D, 1'b1); // integrating on.
			step(8'h00, 1'b0); // edge that takes it.
			ticks = 0;
			repeat (window) begin
				step(8'h00, 1'b0);
				if (sample_tick)
					ticks++;
			end
			check_value($sformatf("ticks, divider %0d", d), 32'(ticks), 32'd64);
			step(8'h0D, 1'b1); // integrating off again.
			step(8'h00, 1'b0);
			ticks = 0;
			repeat (window) begin
				step(8'h00, 1'b0);
				if (sample_tick)
					ticks++;
			end
			check_value($sformatf("ticks idle, divider %0d", d), 32'(ticks), 32'd0);
		end
		report_test("internal ticks", mark);

		// 5. external ticks, delayed by one cycle.
		mark = errors;
		step(8'h3D, 1'b1); // integrating and external.
		step(8'h00, 1'b0);
		prev_ext = 1'b0;
		ext_count = 0;
		tick_count = 0;
		for (int n = 0; n <= EXT_CYCLES; n++) begin
			step(8'h00, 1'b0);
			check_value("sample_tick vs ext_tick", 32'(sample_tick), 32'(prev_ext));
			if (sample_tick)
				tick_count++;
			r = $urandom;
			prev_ext = (n < EXT_CYCLES) && (r[3:0] < 4'd5); // last cycle idle.
			ext_tick = prev_ext;
			if (prev_ext)
				ext_count++;
		end
		check_value("external tick count", 32'(tick_count), 32'(ext_count));
		report_test("external ticks", mark);

		$display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/xc_ctrl_top.sv ====
// correlator control top, plain ports only.
// baud_rate is a register output for a receiver outside this block.
`default_nettype none

module xc_ctrl_top (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire xc_pkg::cmd_t cmd, // host command byte.
	input  wire logic cmd_valid, // one-cycle strobe per byte.
	input  wire logic ext_tick,
	output logic [xc_pkg::NUM_LINES-1:0] pwm,
	output logic sample_tick,
	output logic integrating,
	output logic external_clock,
	output xc_pkg::nibble_t clock_divider,
	output xc_pkg::nibble_t baud_rate,
	output xc_pkg::line_t current_line,
	output xc_pkg::nibble_t [xc_pkg::NUM_LINES-1:0] test,
	output xc_pkg::nibble_t [xc_pkg::NUM_LINES-1:0] leds,
	output xc_pkg::delay_idx_t [xc_pkg::NUM_LINES-1:0] cross_idx,
	output xc_pkg::delay_idx_t [xc_pkg::NUM_LINES-1:0] auto_idx
);

	// settings bus from parser to consumers.
	xc_cfg_if cfg ();

	// capture controls also go out to the correlator.
	assign integrating = cfg.integrating;
	assign external_clock = cfg.external_clock;
	assign clock_divider = cfg.clock_divider;

	// command decode and setting registers.
	cmd_parser u_parser (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd          (cmd),
		.cmd_valid    (cmd_valid),
		.cfg          (cfg.parser),
		.test         (test),
		.leds         (leds),
		.cross_idx    (cross_idx),
		.auto_idx     (auto_idx),
		.baud_rate    (baud_rate),
		.current_line (current_line)
	);

	// bias voltages.
	pwm_bank u_pwm (
		.clk   (clk),
		.rst_n (rst_n),
		.cfg   (cfg.pwm),
		.pwm   (pwm)
	);

	// capture strobe.
	sample_tick_gen u_tick (
		.clk         (clk),
		.rst_n       (rst_n),
		.cfg         (cfg.tick),
		.ext_tick    (ext_tick),
		.sample_tick (sample_tick)
	);

endmodule

`default_nettype wire

// ==== source/sample_tick_gen.sv ====
// capture strobe from the internal divider or an external tick.
// no ticks while integrating is low; external ticks come out one cycle late.
`default_nettype none

module sample_tick_gen (
	input  wire logic clk,
	input  wire logic rst_n,
	xc_cfg_if.tick cfg,
	input  wire logic ext_tick,
	output logic sample_tick
);

	xc_pkg::nibble_t count; // down-counter, period clock_divider+1.
	logic terminal; // divider wrap.

	assign terminal = count == '0;

	// divider.
	// held at the reload value while idle, so a rising
	// integrating flag starts a full period.
	always_ff @(posedge clk) begin
		if (!rst_n)
			count <= '0;
		else if (!cfg.integrating)
			count <= cfg.clock_divider; // idle, keep preloaded.
		else if (terminal)
			count <= cfg.clock_divider; // new divider applies next period.
		else
			count <= count - 1'b1;
	end

	// registered source select.
	// divider 0 gives a tick on every cycle.
	always_ff @(posedge clk) begin
		if (!rst_n)
			sample_tick <= 1'b0;
		else if (cfg.external_clock)
			sample_tick <= cfg.integrating & ext_tick; // one cycle after ext_tick.
		else
			sample_tick <= cfg.integrating & terminal;
	end

endmodule

`default_nettype wire

// ==== source/pwm_bank.sv ====
// one shared 8-bit phase, 256-cycle period for every line.
// outputs are registered, so they trail the phase by one cycle.
`default_nettype none

module pwm_bank (
	input  wire logic clk,
	input  wire logic rst_n,
	xc_cfg_if.pwm cfg,
	output logic [xc_pkg::NUM_LINES-1:0] pwm
);

	xc_pkg::volt_t phase; // free-running, wraps at 256.

	// phase counter.
	always_ff @(posedge clk) begin
		if (!rst_n)
			phase <= '0;
		else
			phase <= phase + 1'b1; // wraps naturally.
	end

	// per-line compare.
	// high while phase < level, so level cycles per period.
	// level 0 never high, 255 low for one cycle.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pwm <= '0;
		end else begin
			for (int i = 0; i < xc_pkg::NUM_LINES; i++) begin
				pwm[i] <= phase < cfg.voltage[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/cmd_parser.sv ====
// takes one command byte per cmd_valid strobe, no back-pressure.
// settings update on the strobe edge; unused opcodes are ignored.
`default_nettype none

module cmd_parser (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire xc_pkg::cmd_t cmd,
	input  wire logic cmd_valid,
	xc_cfg_if.parser cfg,
	output xc_pkg::nibble_t [xc_pkg::NUM_LINES-1:0] test,
	output xc_pkg::nibble_t [xc_pkg::NUM_LINES-1:0] leds,
	output xc_pkg::delay_idx_t [xc_pkg::NUM_LINES-1:0] cross_idx,
	output xc_pkg::delay_idx_t [xc_pkg::NUM_LINES-1:0] auto_idx,
	output xc_pkg::nibble_t baud_rate,
	output xc_pkg::line_t current_line
);

	logic [xc_pkg::LINE_SEL_BITS-1:0] sel; // line the per-line writes go to.
	xc_pkg::opcode_e op;
	logic is_delay; // any of opcodes 4..7.
	logic [3:0] tap_pos; // bit offset of the tap inside the index.
	logic [2:0] fld_pos; // bit offset of a 2-bit field write.

	// decode.
	always_comb begin
		sel = current_line[xc_pkg::LINE_SEL_BITS-1:0];
		op = xc_pkg::opcode_e'(cmd[3:0]);
		is_delay = (cmd[3:0] & xc_pkg::DELAY_MASK) == xc_pkg::SET_DELAY;
		tap_pos = {2'b00, cmd[1:0]} * 4'(xc_pkg::TAP_BITS); // low opcode bits pick tap.
		fld_pos = {1'b0, cmd[7:6]} * 3'(xc_pkg::FIELD_BITS); // pair position.
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg.voltage <= '0;
			cfg.clock_divider <= '0;
			cfg.integrating <= 1'b0;
			cfg.external_clock <= 1'b0;
			test <= '0;
			leds <= '0;
			cross_idx <= '0;
			auto_idx <= '0;
			baud_rate <= '0;
			current_line <= '0;
		end else if (cmd_valid) begin
			if (is_delay) begin
				// cmd[7] picks auto vs cross.
				if (cmd[7])
					auto_idx[sel][tap_pos +: xc_pkg::TAP_BITS] <= cmd[6:4];
				else
					cross_idx[sel][tap_pos +: xc_pkg::TAP_BITS] <= cmd[6:4];
			end else begin
				case (op)
					xc_pkg::CLEAR: begin
						cross_idx[sel] <= '0; // both indices of the line.
						auto_idx[sel] <= '0;
					end
					xc_pkg::SET_LINE: begin
						// built up two bits at a time.
						current_line[fld_pos +: xc_pkg::FIELD_BITS] <= cmd[5:4];
					end
					xc_pkg::SET_LEDS: begin
						leds[sel] <= cmd[7:4];
					end
					xc_pkg::SET_BAUD_RATE: begin
						baud_rate <= cmd[7:4]; // consumed by the external uart.
					end
					xc_pkg::SET_FREQ_DIV: begin
						cfg.clock_divider <= cmd[7:4];
					end
					xc_pkg::SET_VOLTAGE: begin
						// same pair scheme as the line select.
						cfg.voltage[sel][fld_pos +: xc_pkg::FIELD_BITS] <= cmd[5:4];
					end
					xc_pkg::ENABLE_TEST: begin
						test[sel] <= cmd[7:4];
					end
					xc_pkg::ENABLE_CAPTURE: begin
						cfg.integrating <= cmd[4];
						cfg.external_clock <= cmd[5];
					end
					default: begin
						// unused codes, settings hold.
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/xc_cfg_if.sv ====
// parsed settings shared by the parser and its two consumers.
`default_nettype none

interface xc_cfg_if;

	xc_pkg::volt_t [xc_pkg::NUM_LINES-1:0] voltage; // per-line pwm level.
	xc_pkg::nibble_t clock_divider; // internal tick period minus one.
	logic integrating; // capture enable.
	logic external_clock; // tick source select.

	// parser owns every setting.
	modport parser (
		output voltage, clock_divider, integrating, external_clock
	);

	// pwm bank only needs the levels.
	modport pwm (input voltage);

	// tick generator needs the capture controls.
	modport tick (input clock_divider, integrating, external_clock);

endinterface

`default_nettype wire

// ==== source/xc_pkg.sv ====
// shared widths, opcodes and setting types for the correlator control block.
// line count is fixed here; only LINE_SEL_BITS of the line selector are decoded.
`default_nettype none

package xc_pkg;

	// input lines handled by the parser and the pwm bank.
	localparam int NUM_LINES = 4;

	// low selector bits that actually pick a line.
	localparam int LINE_SEL_BITS = 2;

	// width of one field write for voltage and line select.
	localparam int FIELD_BITS = 2;

	// one delay tap inside a 12-bit index.
	localparam int TAP_BITS = 3;

	// delay opcodes 4..7 share the upper two opcode bits.
	localparam logic [3:0] DELAY_MASK = 4'b1100;

	// raw command byte from the host.
	typedef logic [7:0] cmd_t;

	// line selector register, only the low bits are used.
	typedef logic [7:0] line_t;

	// pwm level, also the width of the phase counter.
	typedef logic [7:0] volt_t;

	// test, led, baud and divider values.
	typedef logic [3:0] nibble_t;

	// four 3-bit taps.
	typedef logic [11:0] delay_idx_t;

	// low nibble of the command byte.
	// 5..7 are delay taps too, decoded with DELAY_MASK.
	typedef enum logic [3:0] {
		CLEAR          = 4'd0,
		SET_LINE       = 4'd1,
		SET_LEDS       = 4'd2,
		SET_BAUD_RATE  = 4'd3,
		SET_DELAY      = 4'd4,
		SET_FREQ_DIV   = 4'd8,
		SET_VOLTAGE    = 4'd9,
		ENABLE_TEST    = 4'd12,
		ENABLE_CAPTURE = 4'd13
	} opcode_e;

endpackage

`default_nettype wire
